/* verification/lsu_vectors.txt */
# name kind f0 f1 f2 f3 f4 f5 f6, all fields hex; FAIR: rounds lb_base sb_base
# ADDR/FLUSH/RESET: st rs1 imm idx type vaddr exc; MEM: st paddr value idx type width data; ANS: st idx data
add_lb_dw        ADDR  0 1000 8 1 6 1008 0
add_sb_word_mis  ADDR  1 2000 2 5 4 2002 1
add_lb_half_wrap ADDR  0 fffffffffffffff0 12 3 2 2 0
add_sb_byte_odd  ADDR  1 7 0 2 0 7 0
add_lb_hu_mis    ADDR  0 100 1 4 3 101 1
add_sb_dw_mis    ADDR  1 3000 c 6 6 300c 1
add_lb_wu_ok     ADDR  0 abc0 4 7 5 abc4 0
add_sb_bu_neg    ADDR  1 5000 ffffffffffffffff 0 1 4fff 0
mem_sb_byte      MEM   1 8000 a5 1 0 0 a5
mem_sb_half_u    MEM   1 8002 1234 2 3 1 1234
mem_sb_word_u    MEM   1 8004 deadbeef 3 5 2 deadbeef
mem_sb_dw        MEM   1 8008 0123456789abcdef 4 6 3 0123456789abcdef
mem_lb_byte      MEM   0 9001 ffff 5 0 3 0
mem_lb_word      MEM   0 9004 cafe 6 4 3 0
ans_load         ANS   0 3 1111 0 0 0 0
ans_store        ANS   1 5 0 0 0 0 0
ans_load_again   ANS   0 7 abcd 0 0 0 0
reset_held       RESET 0 10 0 1 0 10 0
fair_vadder      FAIRA 3 100 200 0 0 0 0
fair_dcache      FAIRM 3 a00 b00 0 0 0 0
flush_held       FLUSH 1 4000 8 2 6 4008 0

/* files.f */
+incdir+include
source/lsu_pkg.sv
source/fair_2way_arbiter.sv
source/vadder_stage.sv
source/dcache_port.sv
source/load_store_unit.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
echo "Run finished without failures"

/* include/lsu_tb_checks.svh */
`ifndef LSU_TB_CHECKS_SVH
`define LSU_TB_CHECKS_SVH

// ------------------------------
// Check counters
// ------------------------------

int unsigned pass_cnt = 0;
int unsigned fail_cnt = 0;

// ------------------------------
// Value formatting
// ------------------------------

function automatic string vaddr_ans_text(input vaddr_ans_t ans);
    return $sformatf("st=%0b va=%h idx=%0d exc=%0d",
                     ans.is_store, ans.vaddr, ans.idx, ans.except);
endfunction

function automatic string dcache_req_text(input l1dc_req_t req);
    return $sformatf("pa=%h d=%h type=%0d w=%0d idx=%0d",
                     req.paddr, req.data, req.req_type, req.store_width, req.lsq_addr);
endfunction

// ------------------------------
// Compare tasks
// ------------------------------

// Adder result against the expected one
task automatic check_vaddr_ans(input string test_name, input vaddr_ans_t got,
                               input vaddr_ans_t exp);
    if (got === exp) begin
        pass_cnt++;
    end else begin
        fail_cnt++;
        $display("CHECK FAILED %s: vaddr ans expected %s, actual %s",
                 test_name, vaddr_ans_text(exp), vaddr_ans_text(got));
    end
endtask

// Converted cache request against the expected one
task automatic check_dcache_req(input string test_name, input l1dc_req_t got,
                                input l1dc_req_t exp);
    if (got === exp) begin
        pass_cnt++;
    end else begin
        fail_cnt++;
        $display("CHECK FAILED %s: dcache req expected %s, actual %s",
                 test_name, dcache_req_text(exp), dcache_req_text(got));
    end
endtask

// Single handshake bit, valid or ready
task automatic check_routing(input string test_name, input string sig_name,
                             input logic got, input logic exp);
    if (got === exp) begin
        pass_cnt++;
    end else begin
        fail_cnt++;
        $display("CHECK FAILED %s: %s expected %b, actual %b",
                 test_name, sig_name, exp, got);
    end
endtask

`endif

/* verification/lsu_tb.sv */
module lsu_tb import lsu_pkg::*; ();

    localparam int MAX_TESTS = 64;

    logic          clk_i;
    logic          rst_n_i;
    logic          flush_i;
    logic          lb_addr_valid_i;
    lsb_addr_req_t lb_addr_req_i;
    logic          sb_addr_valid_i;
    lsb_addr_req_t sb_addr_req_i;
    logic          lb_addr_ready_o;
    logic          sb_addr_ready_o;
    vaddr_ans_t    vaddr_ans_o;
    logic          lb_vaddr_valid_o;
    logic          sb_vaddr_valid_o;
    logic          lb_vaddr_ready_i;
    logic          sb_vaddr_ready_i;
    logic          lb_mem_valid_i;
    lsb_mem_req_t  lb_mem_req_i;
    logic          sb_mem_valid_i;
    lsb_mem_req_t  sb_mem_req_i;
    logic          lb_mem_ready_o;
    logic          sb_mem_ready_o;
    logic          dcache_valid_o;
    l1dc_req_t     dcache_req_o;
    logic          dcache_ready_i;
    logic          dcache_ans_valid_i;
    l1dc_ans_t     dcache_ans_i;
    logic          dcache_ans_ready_o;
    logic          lb_ans_valid_o;
    logic          sb_ans_valid_o;
    logic          lb_ans_ready_i;
    logic          sb_ans_ready_i;

    // Vector table
    string       vec_name [0:MAX_TESTS-1];
    string       vec_kind [0:MAX_TESTS-1];
    logic [63:0] vec_fld  [0:MAX_TESTS-1][0:6];
    int          n_tests = 0;

    // Last-served model of both arbiters, 1 means the load side
    logic last_lb_vadder = 1'b1;
    logic last_lb_dcache = 1'b1;

    int seed          = 32'h8bd8;
    int cycle_cnt     = 0;
    int timeout_limit = 50;

    `include "lsu_tb_checks.svh"

    load_store_unit #(
        .STORE_PRIORITY (1'b0)
    ) load_store_unit_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Ends a run whose handshakes stopped moving
    initial begin
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic logic random_ready();
        return ($random(seed) % 4) != 0;
    endfunction

    function automatic lsb_addr_req_t addr_req_from(input int t);
        lsb_addr_req_t req;
        req.is_store  = vec_fld[t][0][0];
        req.rs1_value = vec_fld[t][1];
        req.imm_value = vec_fld[t][2];
        req.idx       = vec_fld[t][3][2:0];
        req.ldst_type = ldst_type_e'(vec_fld[t][4][2:0]);
        return req;
    endfunction

    function automatic vaddr_ans_t ans_from(input int t);
        vaddr_ans_t ans;
        ans.is_store = vec_fld[t][0][0];
        ans.vaddr    = vec_fld[t][5];
        ans.idx      = vec_fld[t][3][2:0];
        ans.except   = vadder_except_e'(vec_fld[t][6][0]);
        return ans;
    endfunction

    task automatic apply_reset();
        @(negedge clk_i);
        rst_n_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;
        last_lb_vadder = 1'b1;
        last_lb_dcache = 1'b1;
    endtask

    task automatic check_idle(input string test_name);
        #1;
        check_routing(test_name, "lb_vaddr_valid_o", lb_vaddr_valid_o, 1'b0);
        check_routing(test_name, "sb_vaddr_valid_o", sb_vaddr_valid_o, 1'b0);
        check_routing(test_name, "dcache_valid_o", dcache_valid_o, 1'b0);
        check_routing(test_name, "lb_ans_valid_o", lb_ans_valid_o, 1'b0);
        check_routing(test_name, "sb_ans_valid_o", sb_ans_valid_o, 1'b0);
    endtask

    // One request into the adder, result side held off
    task automatic send_addr(input lsb_addr_req_t req);
        logic done;
        @(negedge clk_i);
        lb_vaddr_ready_i = 1'b0;
        sb_vaddr_ready_i = 1'b0;
        lb_addr_valid_i  = !req.is_store;
        sb_addr_valid_i  = req.is_store;
        // The idle side shows a different request so a wrong select is seen
        lb_addr_req_i    = req.is_store ? lsb_addr_req_t'(~req) : req;
        sb_addr_req_i    = req.is_store ? req : lsb_addr_req_t'(~req);
        done = 1'b0;
        while (!done) begin
            #1;
            done = req.is_store ? sb_addr_ready_o : lb_addr_ready_o;
            @(negedge clk_i);
        end
        lb_addr_valid_i = 1'b0;
        sb_addr_valid_i = 1'b0;
        last_lb_vadder  = !req.is_store;
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic exercise_adder(input int t);
        lsb_addr_req_t req;
        vaddr_ans_t    exp;
        logic          rdy;
        logic          taken;
        req = addr_req_from(t);
        exp = ans_from(t);
        send_addr(req);
        taken = 1'b0;
        while (!taken) begin
            // Other side stays ready and must not drain the result
            rdy = random_ready();
            lb_vaddr_ready_i = req.is_store ? 1'b1 : rdy;
            sb_vaddr_ready_i = req.is_store ? rdy : 1'b1;
            #1;
            check_routing(vec_name[t], "lb_vaddr_valid_o", lb_vaddr_valid_o, !req.is_store);
            check_routing(vec_name[t], "sb_vaddr_valid_o", sb_vaddr_valid_o, req.is_store);
            check_vaddr_ans(vec_name[t], vaddr_ans_o, exp);
            taken = rdy;
            @(negedge clk_i);
        end
        // A taken result does not come back
        check_idle(vec_name[t]);
    endtask

    task automatic convert_request(input int t);
        lsb_mem_req_t req;
        l1dc_req_t    exp;
        logic         rdy;
        logic         done;
        req.is_store    = vec_fld[t][0][0];
        req.paddr       = vec_fld[t][1];
        req.value       = vec_fld[t][2];
        req.idx         = vec_fld[t][3][2:0];
        req.ldst_type   = ldst_type_e'(vec_fld[t][4][2:0]);
        exp.paddr       = req.paddr;
        exp.data        = vec_fld[t][6];
        exp.req_type    = req.is_store ? STORE : LOAD;
        exp.store_width = store_width_e'(vec_fld[t][5][1:0]);
        exp.lsq_addr    = req.idx;
        @(negedge clk_i);
        lb_mem_valid_i = !req.is_store;
        sb_mem_valid_i = req.is_store;
        lb_mem_req_i   = req.is_store ? lsb_mem_req_t'(~req) : req;
        sb_mem_req_i   = req.is_store ? req : lsb_mem_req_t'(~req);
        done = 1'b0;
        while (!done) begin
            rdy = random_ready();
            dcache_ready_i = rdy;
            #1;
            check_routing(vec_name[t], "dcache_valid_o", dcache_valid_o, 1'b1);
            check_routing(vec_name[t], "granted mem ready",
                          req.is_store ? sb_mem_ready_o : lb_mem_ready_o, rdy);
            check_dcache_req(vec_name[t], dcache_req_o, exp);
            done = rdy;
            @(negedge clk_i);
        end
        lb_mem_valid_i = 1'b0;
        sb_mem_valid_i = 1'b0;
        dcache_ready_i = 1'b0;
        last_lb_dcache = !req.is_store;
        check_idle(vec_name[t]);
    endtask

    task automatic route_answer(input int t);
        l1dc_ans_t ans;
        logic      lb_rdy;
        logic      sb_rdy;
        logic      done;
        ans.was_store = vec_fld[t][0][0];
        ans.lsq_addr  = vec_fld[t][1][2:0];
        ans.data      = vec_fld[t][2];
        @(negedge clk_i);
        dcache_ans_valid_i = 1'b1;
        dcache_ans_i       = ans;
        done = 1'b0;
        while (!done) begin
            lb_rdy = random_ready();
            sb_rdy = random_ready();
            lb_ans_ready_i = lb_rdy;
            sb_ans_ready_i = sb_rdy;
            #1;
            check_routing(vec_name[t], "lb_ans_valid_o", lb_ans_valid_o, !ans.was_store);
            check_routing(vec_name[t], "sb_ans_valid_o", sb_ans_valid_o, ans.was_store);
            check_routing(vec_name[t], "dcache_ans_ready_o", dcache_ans_ready_o,
                          ans.was_store ? sb_rdy : lb_rdy);
            done = ans.was_store ? sb_rdy : lb_rdy;
            @(negedge clk_i);
        end
        dcache_ans_valid_i = 1'b0;
        check_idle(vec_name[t]);
    endtask

    // Both sides keep requesting on the adder or the cache path
    // A new request follows each transfer, so every cycle is contended
    task automatic arbitrate_both(input int t, input logic on_dcache);
        lsb_addr_req_t lb_a;
        lsb_addr_req_t sb_a;
        lsb_mem_req_t  lb_m;
        lsb_mem_req_t  sb_m;
        int            rounds;
        int            n_lb;
        int            n_sb;
        logic          pend_lb;
        logic          pend_sb;
        logic          got_lb;
        logic          got_sb;
        logic          exp_lb;
        rounds = int'(vec_fld[t][0]);
        n_lb   = 0;
        n_sb   = 0;
        @(negedge clk_i);
        lb_vaddr_ready_i = 1'b1;
        sb_vaddr_ready_i = 1'b1;
        dcache_ready_i   = 1'b1;
        while (n_lb < rounds || n_sb < rounds) begin
            pend_lb = n_lb < rounds;
            pend_sb = n_sb < rounds;
            lb_a = '0;
            sb_a = '0;
            lb_m = '0;
            sb_m = '0;
            lb_a.rs1_value = vec_fld[t][1] + 64'(n_lb);
            sb_a.rs1_value = vec_fld[t][2] + 64'(n_sb);
            sb_a.is_store  = 1'b1;
            lb_m.paddr     = vec_fld[t][1] + 64'(n_lb);
            sb_m.paddr     = vec_fld[t][2] + 64'(n_sb);
            sb_m.is_store  = 1'b1;
            lb_addr_req_i  = lb_a;
            sb_addr_req_i  = sb_a;
            lb_mem_req_i   = lb_m;
            sb_mem_req_i   = sb_m;
            lb_addr_valid_i = !on_dcache && pend_lb;
            sb_addr_valid_i = !on_dcache && pend_sb;
            lb_mem_valid_i  = on_dcache && pend_lb;
            sb_mem_valid_i  = on_dcache && pend_sb;
            #1;
            got_lb = on_dcache ? lb_mem_ready_o : lb_addr_ready_o;
            got_sb = on_dcache ? sb_mem_ready_o : sb_addr_ready_o;
            // Under contention the side not served last time goes first
            if (pend_lb && pend_sb) begin
                exp_lb = on_dcache ? !last_lb_dcache : !last_lb_vadder;
            end else begin
                exp_lb = pend_lb;
            end
            check_routing(vec_name[t], "load side ready", got_lb, exp_lb);
            check_routing(vec_name[t], "store side ready", got_sb, !exp_lb);
            if (on_dcache) begin
                last_lb_dcache = exp_lb;
            end else begin
                last_lb_vadder = exp_lb;
            end
            @(negedge clk_i);
            if (pend_lb && got_lb) begin
                n_lb++;
            end
            if (pend_sb && got_sb) begin
                n_sb++;
            end
        end
        lb_addr_valid_i = 1'b0;
        sb_addr_valid_i = 1'b0;
        lb_mem_valid_i  = 1'b0;
        sb_mem_valid_i  = 1'b0;
        // Let the last adder result drain
        @(negedge clk_i);
        check_idle(vec_name[t]);
    endtask

    task automatic flush_held_result(input int t);
        lsb_addr_req_t req;
        req = addr_req_from(t);
        send_addr(req);
        #1;
        check_routing(vec_name[t], "held result valid",
                      req.is_store ? sb_vaddr_valid_o : lb_vaddr_valid_o, 1'b1);
        check_vaddr_ans(vec_name[t], vaddr_ans_o, ans_from(t));
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        check_idle(vec_name[t]);
    endtask

    task automatic reset_held_result(input int t);
        lsb_addr_req_t req;
        req = addr_req_from(t);
        send_addr(req);
        #1;
        check_routing(vec_name[t], "held result valid",
                      req.is_store ? sb_vaddr_valid_o : lb_vaddr_valid_o, 1'b1);
        check_vaddr_ans(vec_name[t], vaddr_ans_o, ans_from(t));
        apply_reset();
        check_idle(vec_name[t]);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int          fd;
        int          code;
        int          tests_ok;
        int          tests_bad;
        int unsigned fails_before;
        string       nm;
        string       kd;
        string       line;
        logic [63:0] fv [0:6];
        rst_n_i            = 1'b0;
        flush_i            = 1'b0;
        lb_addr_valid_i    = 1'b0;
        sb_addr_valid_i    = 1'b0;
        lb_addr_req_i      = '0;
        sb_addr_req_i      = '0;
        lb_vaddr_ready_i   = 1'b0;
        sb_vaddr_ready_i   = 1'b0;
        lb_mem_valid_i     = 1'b0;
        sb_mem_valid_i     = 1'b0;
        lb_mem_req_i       = '0;
        sb_mem_req_i       = '0;
        dcache_ready_i     = 1'b0;
        dcache_ans_valid_i = 1'b0;
        dcache_ans_i       = '0;
        lb_ans_ready_i     = 1'b0;
        sb_ans_ready_i     = 1'b0;
        tests_ok  = 0;
        tests_bad = 0;

        fd = $fopen("verification/lsu_vectors.txt", "r");
        if (fd == 0) begin
            $display("Vector file verification/lsu_vectors.txt could not be opened");
            fail_cnt++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fscanf(fd, "%s", nm);
                if (code == 1 && nm.substr(0, 0) == "#") begin
                    code = $fgets(line, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, "%s %h %h %h %h %h %h %h", kd,
                                   fv[0], fv[1], fv[2], fv[3], fv[4], fv[5], fv[6]);
                    if (code == 8) begin
                        vec_name[n_tests] = nm;
                        vec_kind[n_tests] = kd;
                        for (int i = 0; i < 7; i++) begin
                            vec_fld[n_tests][i] = fv[i];
                        end
                        n_tests++;
                    end else begin
                        $display("Vector line of test %s could not be parsed", nm);
                        fail_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_tests == 0) begin
            $display("No test vectors were loaded");
            fail_cnt++;
        end
        timeout_limit = 20 * n_tests + 50;

        apply_reset();
        check_idle("after_reset");

        for (int t = 0; t < n_tests; t++) begin
            fails_before = fail_cnt;
            case (vec_kind[t])
                "ADDR":  exercise_adder(t);
                "MEM":   convert_request(t);
                "ANS":   route_answer(t);
                "FAIRA": arbitrate_both(t, 1'b0);
                "FAIRM": arbitrate_both(t, 1'b1);
                "FLUSH": flush_held_result(t);
                "RESET": reset_held_result(t);
                default: begin
                    $display("Test %s has the unknown kind %s", vec_name[t], vec_kind[t]);
                    fail_cnt++;
                end
            endcase
            if (fail_cnt == fails_before) begin
                tests_ok++;
                $display("PASS %s", vec_name[t]);
            end else begin
                tests_bad++;
                $display("FAIL %s", vec_name[t]);
            end
        end

        $display("Tests: %0d passed, %0d failed; checks: %0d passed, %0d failed",
                 tests_ok, tests_bad, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* source/load_store_unit.sv */
module load_store_unit import lsu_pkg::*; #(
    parameter bit STORE_PRIORITY = 1'b0
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          flush_i,

    // Buffers to address adder
    input  logic          lb_addr_valid_i,
    input  lsb_addr_req_t lb_addr_req_i,
    input  logic          sb_addr_valid_i,
    input  lsb_addr_req_t sb_addr_req_i,
    output logic          lb_addr_ready_o,
    output logic          sb_addr_ready_o,

    // Address adder to buffers
    output vaddr_ans_t    vaddr_ans_o,
    output logic          lb_vaddr_valid_o,
    output logic          sb_vaddr_valid_o,
    input  logic          lb_vaddr_ready_i,
    input  logic          sb_vaddr_ready_i,

    // Buffers to data cache
    input  logic          lb_mem_valid_i,
    input  lsb_mem_req_t  lb_mem_req_i,
    input  logic          sb_mem_valid_i,
    input  lsb_mem_req_t  sb_mem_req_i,
    output logic          lb_mem_ready_o,
    output logic          sb_mem_ready_o,
    output logic          dcache_valid_o,
    output l1dc_req_t     dcache_req_o,
    input  logic          dcache_ready_i,

    // Data cache answers
    input  logic          dcache_ans_valid_i,
    input  l1dc_ans_t     dcache_ans_i,
    output logic          dcache_ans_ready_o,
    output logic          lb_ans_valid_o,
    output logic          sb_ans_valid_o,
    input  logic          lb_ans_ready_i,
    input  logic          sb_ans_ready_i
);

    logic vadder_arb_valid;
    logic vadder_arb_ready;
    logic vadder_select_lb;
    logic dcache_arb_valid;
    logic dcache_select_lb;

    // ------------------------------
    // Address adder path
    // ------------------------------

    fair_2way_arbiter #(
        .STORE_PRIORITY (STORE_PRIORITY)
    ) u_vadder_arbiter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lb_valid_i     (lb_addr_valid_i),
        .sb_valid_i     (sb_addr_valid_i),
        .ready_i        (vadder_arb_ready),
        .valid_o        (vadder_arb_valid),
        .lb_ready_o     (lb_addr_ready_o),
        .sb_ready_o     (sb_addr_ready_o),
        .select_lb_o    (vadder_select_lb)
    );

    vadder_stage u_vadder_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .arb_valid_i    (vadder_arb_valid),
        .select_lb_i    (vadder_select_lb),
        .lb_req_i       (lb_addr_req_i),
        .sb_req_i       (sb_addr_req_i),
        .arb_ready_o    (vadder_arb_ready),
        .lb_ready_i     (lb_vaddr_ready_i),
        .sb_ready_i     (sb_vaddr_ready_i),
        .lb_valid_o     (lb_vaddr_valid_o),
        .sb_valid_o     (sb_vaddr_valid_o),
        .ans_o          (vaddr_ans_o)
    );

    // ------------------------------
    // Data cache path
    // ------------------------------

    fair_2way_arbiter #(
        .STORE_PRIORITY (STORE_PRIORITY)
    ) u_dcache_arbiter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lb_valid_i     (lb_mem_valid_i),
        .sb_valid_i     (sb_mem_valid_i),
        .ready_i        (dcache_ready_i),
        .valid_o        (dcache_arb_valid),
        .lb_ready_o     (lb_mem_ready_o),
        .sb_ready_o     (sb_mem_ready_o),
        .select_lb_o    (dcache_select_lb)
    );

    dcache_port u_dcache_port (
        .select_lb_i        (dcache_select_lb),
        .arb_valid_i        (dcache_arb_valid),
        .lb_req_i           (lb_mem_req_i),
        .sb_req_i           (sb_mem_req_i),
        .dcache_valid_o     (dcache_valid_o),
        .dcache_req_o       (dcache_req_o),
        .dcache_ans_valid_i (dcache_ans_valid_i),
        .dcache_ans_i       (dcache_ans_i),
        .lb_ans_ready_i     (lb_ans_ready_i),
        .sb_ans_ready_i     (sb_ans_ready_i),
        .dcache_ans_ready_o (dcache_ans_ready_o),
        .lb_ans_valid_o     (lb_ans_valid_o),
        .sb_ans_valid_o     (sb_ans_valid_o)
    );

endmodule

/* source/dcache_port.sv */
module dcache_port import lsu_pkg::*; (
    // Request side
    input  logic         select_lb_i,
    input  logic         arb_valid_i,
    input  lsb_mem_req_t lb_req_i,
    input  lsb_mem_req_t sb_req_i,
    output logic         dcache_valid_o,
    output l1dc_req_t    dcache_req_o,

    // Answer side
    input  logic         dcache_ans_valid_i,
    input  l1dc_ans_t    dcache_ans_i,
    input  logic         lb_ans_ready_i,
    input  logic         sb_ans_ready_i,
    output logic         dcache_ans_ready_o,
    output logic         lb_ans_valid_o,
    output logic         sb_ans_valid_o
);

    lsb_mem_req_t req_mux;
    store_width_e width_d;

    // ------------------------------
    // Request mux
    // ------------------------------

    assign req_mux = select_lb_i ? lb_req_i : sb_req_i;

    // ------------------------------
    // Type conversion
    // ------------------------------

    always_comb begin
        case (req_mux.ldst_type)
            LS_BYTE, LS_BYTE_U:         width_d = B;
            LS_HALFWORD, LS_HALFWORD_U: width_d = HW;
            LS_WORD, LS_WORD_U:         width_d = W;
            LS_DOUBLEWORD:              width_d = DW;
            default:                    width_d = DW;
        endcase
    end

    always_comb begin
        dcache_req_o.paddr    = req_mux.paddr;
        dcache_req_o.lsq_addr = req_mux.idx;
        if (req_mux.is_store) begin
            dcache_req_o.req_type    = STORE;
            dcache_req_o.data        = req_mux.value;
            dcache_req_o.store_width = width_d;
        end else begin
            // Loads fetch the whole doubleword and carry no data
            dcache_req_o.req_type    = LOAD;
            dcache_req_o.data        = '0;
            dcache_req_o.store_width = DW;
        end
    end

    assign dcache_valid_o = arb_valid_i;

    // ------------------------------
    // Answer handshake decoder
    // ------------------------------

    always_comb begin
        if (dcache_ans_i.was_store) begin
            lb_ans_valid_o     = 1'b0;
            sb_ans_valid_o     = dcache_ans_valid_i;
            dcache_ans_ready_o = sb_ans_ready_i;
        end else begin
            lb_ans_valid_o     = dcache_ans_valid_i;
            sb_ans_valid_o     = 1'b0;
            dcache_ans_ready_o = lb_ans_ready_i;
        end
    end

    // One answer goes to exactly one buffer
    always_comb begin
        a_one_ans_valid: assert (!(lb_ans_valid_o && sb_ans_valid_o))
            else $error("Cache answer routed to both buffers");
    end

endmodule

/* source/vadder_stage.sv */
module vadder_stage import lsu_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          flush_i,

    // Arbiter side
    input  logic          arb_valid_i,
    input  logic          select_lb_i,
    input  lsb_addr_req_t lb_req_i,
    input  lsb_addr_req_t sb_req_i,
    output logic          arb_ready_o,

    // Result side, shared data and per-buffer valid/ready
    input  logic          lb_ready_i,
    input  logic          sb_ready_i,
    output logic          lb_valid_o,
    output logic          sb_valid_o,
    output vaddr_ans_t    ans_o
);

    lsb_addr_req_t   req_mux;
    logic [XLEN-1:0] vaddr_sum;
    logic [2:0]      align_mask;
    vadder_except_e  except_d;
    logic            out_ready;
    logic            accept;
    logic            valid_q;
    vaddr_ans_t      ans_q;

    // ------------------------------
    // Request mux and adder
    // ------------------------------

    assign req_mux   = select_lb_i ? lb_req_i : sb_req_i;
    assign vaddr_sum = req_mux.rs1_value + req_mux.imm_value;

    // Low address bits that must be zero for each access size
    always_comb begin
        case (req_mux.ldst_type)
            LS_BYTE, LS_BYTE_U:         align_mask = 3'b000;
            LS_HALFWORD, LS_HALFWORD_U: align_mask = 3'b001;
            LS_WORD, LS_WORD_U:         align_mask = 3'b011;
            LS_DOUBLEWORD:              align_mask = 3'b111;
            default:                    align_mask = 3'b111;
        endcase
    end

    assign except_d = |(vaddr_sum[2:0] & align_mask) ? VADDER_MISALIGNED : VADDER_OK;

    // ------------------------------
    // Result register
    // ------------------------------

    // Ready of the side the held result belongs to
    assign out_ready   = ans_q.is_store ? sb_ready_i : lb_ready_i;
    // Free when empty or being drained this cycle
    assign arb_ready_o = !valid_q || out_ready;
    assign accept      = arb_valid_i && arb_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (arb_ready_o) begin
            valid_q <= arb_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ans_q.is_store <= req_mux.is_store;
            ans_q.vaddr    <= vaddr_sum;
            ans_q.idx      <= req_mux.idx;
            ans_q.except   <= except_d;
        end
    end

    // ------------------------------
    // Answer decoder
    // ------------------------------

    assign lb_valid_o = valid_q && !ans_q.is_store;
    assign sb_valid_o = valid_q && ans_q.is_store;
    assign ans_o      = ans_q;

    // A stalled result keeps its data and its valid until taken
    a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (((lb_valid_o && !lb_ready_i) || (sb_valid_o && !sb_ready_i)) && !flush_i)
        |=> ($stable(ans_o) && $stable({lb_valid_o, sb_valid_o})))
        else $error("Adder result changed under back-pressure");

endmodule

/* source/fair_2way_arbiter.sv */
module fair_2way_arbiter import lsu_pkg::*; #(
    parameter bit STORE_PRIORITY = 1'b0
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic lb_valid_i,
    input  logic sb_valid_i,
    input  logic ready_i,
    output logic valid_o,
    output logic lb_ready_o,
    output logic sb_ready_o,
    output logic select_lb_o
);

    arb_side_e last_served_q;
    logic      xfer;

    // ------------------------------
    // Selection
    // ------------------------------

    always_comb begin
        if (lb_valid_i && !sb_valid_i) begin
            select_lb_o = 1'b1;
        end else if (sb_valid_i && !lb_valid_i) begin
            select_lb_o = 1'b0;
        end else if (lb_valid_i && sb_valid_i) begin
            // Contention: store wins, or the side that waited last time
            select_lb_o = STORE_PRIORITY ? 1'b0 : (last_served_q == SIDE_SB);
        end else begin
            select_lb_o = 1'b0;
        end
    end

    assign valid_o    = lb_valid_i || sb_valid_i;
    assign lb_ready_o = ready_i && select_lb_o;
    assign sb_ready_o = ready_i && !select_lb_o;
    assign xfer       = valid_o && ready_i;

    // Last-served side, moves only on a transfer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_served_q <= SIDE_LB;
        end else if (xfer) begin
            last_served_q <= select_lb_o ? SIDE_LB : SIDE_SB;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(lb_ready_o && sb_ready_o))
        else $error("Both sides granted in the same cycle");

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Data and address width
    localparam int unsigned XLEN         = 64;
    // Buffer entry index, shared by the load and store buffers
    localparam int unsigned BUFF_IDX_LEN = 3;

    // ------------------------------
    // Enums
    // ------------------------------

    // Memory access type, as issued to the buffers
    typedef enum logic [2:0] {
        LS_BYTE,
        LS_BYTE_U,
        LS_HALFWORD,
        LS_HALFWORD_U,
        LS_WORD,
        LS_WORD_U,
        LS_DOUBLEWORD
    } ldst_type_e;

    // Store width in the data cache request
    typedef enum logic [1:0] {
        B,
        HW,
        W,
        DW
    } store_width_e;

    // Data cache request kind
    typedef enum logic {
        LOAD,
        STORE
    } req_type_e;

    // Address adder exception
    typedef enum logic {
        VADDER_OK,
        VADDER_MISALIGNED
    } vadder_except_e;

    // Last side served by a two-way arbiter
    typedef enum logic {
        SIDE_LB,
        SIDE_SB
    } arb_side_e;

    // ------------------------------
    // Request and answer structs
    // ------------------------------

    // Buffer to address adder
    typedef struct packed {
        logic                    is_store;
        logic [XLEN-1:0]         rs1_value;
        logic [XLEN-1:0]         imm_value;
        logic [BUFF_IDX_LEN-1:0] idx;
        ldst_type_e              ldst_type;
    } lsb_addr_req_t;

    // Address adder to both buffers
    typedef struct packed {
        logic                    is_store;
        logic [XLEN-1:0]         vaddr;
        logic [BUFF_IDX_LEN-1:0] idx;
        vadder_except_e          except;
    } vaddr_ans_t;

    // Buffer to data cache, before conversion
    typedef struct packed {
        logic                    is_store;
        logic [XLEN-1:0]         paddr;
        logic [XLEN-1:0]         value;
        logic [BUFF_IDX_LEN-1:0] idx;
        ldst_type_e              ldst_type;
    } lsb_mem_req_t;

    // Request in data cache format
    typedef struct packed {
        logic [XLEN-1:0]         paddr;
        logic [XLEN-1:0]         data;
        req_type_e               req_type;
        store_width_e            store_width;
        logic [BUFF_IDX_LEN-1:0] lsq_addr;
    } l1dc_req_t;

    // Data cache answer
    typedef struct packed {
        logic [XLEN-1:0]         data;
        logic [BUFF_IDX_LEN-1:0] lsq_addr;
        logic                    was_store;
    } l1dc_ans_t;

endpackage
